// File: build.f
src/ddr_app_pkg.sv
src/tester_pkg.sv
src/pattern_gen.sv
src/read_checker.sv
src/ddr_app_port.sv
src/test_sequencer.sv
src/ddr_test_top.sv
verif/ddr_mem_model.sv
verif/ddr_test_assertions.sv
verif/tb_ddr_test.sv

// File: verif/tb_ddr_test.sv
`timescale 1ns/1ns

module tb_ddr_test
  import ddr_app_pkg::*;
  import tester_pkg::*;
();

  localparam int ROW_W        = 1;
  localparam int LIN_W        = ROW_W + BANK_W + COL_W;
  localparam int NUM_ROWS     = 7;
  localparam int RESET_CYCLES = 8;
  // four passes over the large region at 64 cycles per burst
  localparam longint SWEEP_CYCLES = CALIB_HOLD + 4 * (2 ** LIN_W / BURST_ADDR_STEP) * 64;
  localparam longint WATCHDOG_NS  = NUM_ROWS * (SWEEP_CYCLES + RESET_CYCLES + 64) * 10;
  localparam logic [1:0] FAULT_NONE  = 2'd0;
  localparam logic [1:0] FAULT_STUCK = 2'd1;
  localparam logic [1:0] FAULT_FLIP  = 2'd2;

  typedef struct packed {
    logic        aliased;
    logic [1:0]  fault_kind;
    logic [10:0] fault_idx;
    logic [6:0]  fault_bit;
    logic        bp_en;
    logic [8:0]  calib_drop;
    logic        exp_large;
    logic        exp_detect_err;
    logic        exp_mismatch;
    test_phase_t exp_phase;
  } test_row_t;

  logic                  clk;
  logic                  rstn;
  logic                  calib_done;
  app_ready_t            app_rdy;
  app_rdata_t            app_rd;
  app_cmd_t              app_cmd;
  app_wdata_t            app_wr;
  test_status_t          status;
  test_row_t             rows [NUM_ROWS];
  test_row_t             cur;
  logic [LIN_W-4:0]      fault_word;
  logic [APP_DATA_W-1:0] exp_word;
  int                    n_bursts;
  int                    err_cnt;
  int                    check_cnt;
  int                    cmd_idx;
  int                    wr_idx;
  int                    hi_cnt;

  ddr_test_top #(
    .ROW_W(ROW_W)
  ) i_ddr_test_top (
    .clk         (clk),
    .rstn        (rstn),
    .calib_done_i(calib_done),
    .app_rdy_i   (app_rdy),
    .app_rd_i    (app_rd),
    .app_cmd_o   (app_cmd),
    .app_wr_o    (app_wr),
    .status_o    (status)
  );

  ddr_mem_model #(
    .ROW_W(ROW_W)
  ) i_ddr_mem_model (
    .clk         (clk),
    .rstn        (rstn),
    .alias_i     (cur.aliased),
    .stuck_en_i  (cur.fault_kind == FAULT_STUCK),
    .flip_i      (cur.fault_kind == FAULT_FLIP),
    .fault_word_i(fault_word),
    .fault_bit_i (cur.fault_bit),
    .bp_en_i     (cur.bp_en),
    .cmd_i       (app_cmd),
    .wr_i        (app_wr),
    .rdy_o       (app_rdy),
    .rd_o        (app_rd)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the last test reached done");
    $display("ERRORS FOUND");
    $finish;
  end

  // 128 shifts per word with taps 68 67 66 63 into bit 0
  function automatic logic [APP_DATA_W-1:0] advance_word(input logic [APP_DATA_W-1:0] w);
    logic [APP_DATA_W-1:0] s;
    s = w;
    repeat (128) begin
      s = {s[APP_DATA_W-2:0], s[68] ^ s[67] ^ s[66] ^ s[63]};
    end
    return s;
  endfunction

  // linear row bank col onto controller bank row col
  function automatic logic [APP_ADDR_W-1:0] remap(input logic [LIN_W-1:0] lin);
    return APP_ADDR_W'({lin[COL_W +: BANK_W], lin[COL_W+BANK_W +: ROW_W], lin[COL_W-1:0]});
  endfunction

  function automatic test_phase_t stuck_phase(input logic [10:0] idx, input logic [6:0] bit_sel);
    logic [APP_DATA_W-1:0] w;
    w = LFSR_SEED;
    for (int i = 0; i <= int'(idx); i++) begin
      w = advance_word(w);
    end
    // stuck zero only shows in the normal pass where the word holds a one
    return w[bit_sel] ? check : inv_check;
  endfunction

  function automatic app_cmd_t expected_cmd(input int n);
    app_cmd_t c;
    int       m;
    m           = n - 3;
    c.en        = (n < 3) || (!cur.exp_detect_err && m < 4 * n_bursts);
    c.cmd       = (n == 2 || (n > 2 && (m / n_bursts) % 2 == 1)) ? CMD_RD : CMD_WR;
    c.addr      = (n == 1) ? remap(LIN_W'(1) << (LIN_W - 1)) :
                  (n < 3) ? '0 : remap(LIN_W'(BURST_ADDR_STEP * (m % n_bursts)));
    c.burst_num = (n < 3) ? 6'd0 : 6'(BURST_BEATS - 1);
    return c;
  endfunction

  task automatic compare_cmd(input app_cmd_t act, input app_cmd_t exp, input int idx);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t: command %0d is %h, expected %h", $time, idx, act, exp);
    end
  endtask

  task automatic compare_word(input app_wdata_t act, input app_wdata_t exp, input int idx);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t: write beat %0d is %h, expected %h", $time, idx, act, exp);
    end
  endtask

  task automatic compare_status(input test_status_t act, input test_status_t exp);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t: status is %b, expected %b", $time, act, exp);
    end
  endtask

  function automatic int total_errors();
    return err_cnt + i_ddr_test_top.i_ddr_test_assertions.fail_cnt;
  endfunction

  // command and write monitor sampled mid-cycle
  always @(negedge clk) begin
    app_wdata_t exp_wr;
    int         m;
    int         n_words;
    if (!rstn) begin
      cmd_idx = 0;
      wr_idx  = 0;
      hi_cnt  = 0;
    end else begin
      hi_cnt = calib_done ? hi_cnt + 1 : 0;
      if (app_cmd.en) begin
        if (cmd_idx == 0 && hi_cnt < CALIB_HOLD) begin
          err_cnt++;
          $display("%0t: first command after only %0d calibrated cycles", $time, hi_cnt);
        end
        compare_cmd(app_cmd, expected_cmd(cmd_idx), cmd_idx);
        cmd_idx++;
      end
      if (app_wr.en) begin
        n_words          = n_bursts * BURST_BEATS;
        m                = wr_idx - 2;
        exp_wr.en        = (wr_idx < 2) || (!cur.exp_detect_err && m < 2 * n_words);
        exp_wr.data_end  = 1'b1;
        if (wr_idx < 2) begin
          exp_wr.data = (wr_idx == 0) ? PAT_LOW : PAT_HIGH;
        end else begin
          exp_word    = (m % n_words == 0) ? advance_word(LFSR_SEED) : advance_word(exp_word);
          exp_wr.data = ((m / n_words) % 2 == 1) ? ~exp_word : exp_word;
        end
        compare_word(app_wr, exp_wr, wr_idx);
        wr_idx++;
      end
    end
  end

  task automatic apply_row(input test_row_t r);
    test_status_t     exp_st;
    logic [LIN_W-1:0] fault_addr;
    int               cyc;
    int               exp_writes;
    int               exp_cmds;
    @(posedge clk);
    #1;
    rstn       = 1'b0;
    calib_done = 1'b0;
    cur        = r;
    fault_addr = LIN_W'(remap({r.fault_idx, 3'b000}));
    fault_word = fault_addr[LIN_W-1:3];
    n_bursts   = (r.exp_large ? 2 ** LIN_W : 2 ** (LIN_W - 1)) / BURST_ADDR_STEP;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rstn       = 1'b1;
    calib_done = 1'b1;
    cyc        = 0;
    while (!status.done) begin
      @(posedge clk);
      #1;
      cyc++;
      calib_done = (cyc != int'(r.calib_drop));
    end
    // trailing read beats drain before the status check
    repeat (16) @(posedge clk);
    #1;
    exp_st = '{1'b1, r.exp_large, r.exp_detect_err, r.exp_mismatch, r.exp_phase};
    if (r.fault_kind == FAULT_STUCK) begin
      exp_st.fail_phase = stuck_phase(r.fault_idx, r.fault_bit);
    end
    compare_status(status, exp_st);
    // beat and command totals of the whole run
    if (exp_st.detect_err) begin
      exp_writes = 2;
      exp_cmds   = 3;
    end else if (exp_st.mismatch && exp_st.fail_phase == check) begin
      exp_writes = 2 + n_bursts * BURST_BEATS;
      exp_cmds   = 0;
    end else begin
      exp_writes = 2 + 2 * n_bursts * BURST_BEATS;
      exp_cmds   = 3 + 4 * n_bursts;
    end
    check_cnt++;
    if (wr_idx != exp_writes) begin
      err_cnt++;
      $display("[FAIL] %0t: %0d write beats seen, expected %0d", $time, wr_idx, exp_writes);
    end
    if (!exp_st.mismatch) begin
      check_cnt++;
      if (cmd_idx != exp_cmds) begin
        err_cnt++;
        $display("[FAIL] %0t: %0d commands seen, expected %0d", $time, cmd_idx, exp_cmds);
      end
    end
  endtask

  initial begin
    int errs_before;
    rstn       = 1'b0;
    calib_done = 1'b0;
    fault_word = '0;
    err_cnt    = 0;
    check_cnt  = 0;
    n_bursts   = 1;
    // alias, fault, idx, bit, bp, drop, large, det_err, mismatch, phase
    rows[0] = '{1'b0, FAULT_NONE, 11'd0, 7'd0, 1'b0, 9'd0, 1'b1, 1'b0, 1'b0, wait_init};
    rows[1] = '{1'b1, FAULT_NONE, 11'd0, 7'd0, 1'b0, 9'd0, 1'b0, 1'b0, 1'b0, wait_init};
    rows[2] = '{1'b0, FAULT_STUCK, 11'd37, 7'd5, 1'b0, 9'd0, 1'b1, 1'b0, 1'b1, check};
    rows[3] = '{1'b0, FAULT_STUCK, 11'd1500, 7'd77, 1'b0, 9'd0, 1'b1, 1'b0, 1'b1, check};
    rows[4] = '{1'b0, FAULT_FLIP, 11'd0, 7'd0, 1'b0, 9'd0, 1'b0, 1'b1, 1'b0, wait_init};
    rows[5] = '{1'b0, FAULT_NONE, 11'd0, 7'd0, 1'b1, 9'd0, 1'b1, 1'b0, 1'b0, wait_init};
    rows[6] = '{1'b0, FAULT_NONE, 11'd0, 7'd0, 1'b0, 9'd100, 1'b1, 1'b0, 1'b0, wait_init};
    cur = rows[0];
    for (int t = 0; t < NUM_ROWS; t++) begin
      errs_before = total_errors();
      apply_row(rows[t]);
      $display("test %0d %s", t, (total_errors() == errs_before) ? "ok" : "failed");
    end
    $display("tests %0d, checks %0d, errors %0d", NUM_ROWS, check_cnt, total_errors());
    if (total_errors() == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: verif/ddr_test_assertions.sv
`timescale 1ns/1ns

module ddr_test_assertions
  import ddr_app_pkg::*;
  import tester_pkg::*;
(
  input logic         clk,
  input logic         rstn,
  input app_ready_t   rdy_i,
  input app_rdata_t   rd_i,
  input app_cmd_t     cmd_i,
  input app_wdata_t   wr_i,
  input test_status_t status_i
);

  int  pending;
  int  fail_cnt = 0;
  logic rd_cmd;

  assign rd_cmd = cmd_i.en && (cmd_i.cmd == CMD_RD);

  // read beats still owed by the controller
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pending <= 0;
    end else begin
      pending <= pending + (rd_cmd ? int'(cmd_i.burst_num) + 1 : 0) - (rd_i.valid ? 1 : 0);
    end
  end

  cmd_needs_ready: assert property (@(posedge clk) disable iff (!rstn)
    cmd_i.en |-> rdy_i.cmd_rdy)
    else begin
      $error("command enable while command ready is low");
      fail_cnt++;
    end

  wr_needs_ready: assert property (@(posedge clk) disable iff (!rstn)
    wr_i.en |-> rdy_i.wdata_rdy)
    else begin
      $error("write data enable while write-data ready is low");
      fail_cnt++;
    end

  one_read_in_flight: assert property (@(posedge clk) disable iff (!rstn)
    rd_cmd |-> pending == 0)
    else begin
      $error("read command issued before the previous burst returned");
      fail_cnt++;
    end

  done_holds: assert property (@(posedge clk) disable iff (!rstn)
    status_i.done |=> status_i.done)
    else begin
      $error("done dropped before reset");
      fail_cnt++;
    end

endmodule

bind ddr_test_top ddr_test_assertions i_ddr_test_assertions (
  .clk     (clk),
  .rstn    (rstn),
  .rdy_i   (app_rdy_i),
  .rd_i    (app_rd_i),
  .cmd_i   (app_cmd_o),
  .wr_i    (app_wr_o),
  .status_i(status_o)
);

// File: verif/ddr_mem_model.sv
`timescale 1ns/1ns

module ddr_mem_model
  import ddr_app_pkg::*;
#(
  parameter int ROW_W = 14
) (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              alias_i,
  input  logic                              stuck_en_i,
  input  logic                              flip_i,
  input  logic [ROW_W+BANK_W+COL_W-4:0]     fault_word_i,
  input  logic [6:0]                        fault_bit_i,
  input  logic                              bp_en_i,
  input  app_cmd_t                          cmd_i,
  input  app_wdata_t                        wr_i,
  output app_ready_t                        rdy_o,
  output app_rdata_t                        rd_o
);

  localparam int WORD_W = ROW_W + BANK_W + COL_W - 3;

  logic [APP_DATA_W-1:0] mem [2**WORD_W];
  logic [APP_DATA_W-1:0] wq [$];
  logic [APP_DATA_W-1:0] rq [$];
  integer                seed;

  initial begin
    seed  = 32'hdec4_0881;
    rdy_o = '0;
    rd_o  = '0;
  end

  // accepted beats and commands, taken mid-cycle where they are stable
  always @(negedge clk) begin
    logic [WORD_W-1:0]     idx;
    logic [APP_DATA_W-1:0] d;
    if (!rstn) begin
      wq.delete();
      rq.delete();
      for (int i = 0; i < 2**WORD_W; i++) begin
        mem[i] = {4{32'(i) ^ 32'h3c5a_0f96}};
      end
    end else begin
      if (wr_i.en) begin
        wq.push_back(wr_i.data);
      end
      if (cmd_i.en) begin
        for (int b = 0; b <= int'(cmd_i.burst_num); b++) begin
          idx = cmd_i.addr[WORD_W+2:3] + WORD_W'(b);
          // small part ignores the top row bit
          if (alias_i) begin
            idx[COL_W+ROW_W-4] = 1'b0;
          end
          if (cmd_i.cmd == CMD_WR) begin
            mem[idx] = wq.pop_front();
          end else begin
            d = mem[idx];
            if (stuck_en_i && idx == fault_word_i) begin
              d[fault_bit_i] = 1'b0;
            end
            rq.push_back(flip_i ? ~d : d);
          end
        end
      end
    end
  end

  // ready levels and read beats change just after the rising edge
  always @(posedge clk) begin
    #1;
    rdy_o.cmd_rdy   = !bp_en_i || ($random(seed) % 4 != 0);
    rdy_o.wdata_rdy = !bp_en_i || ($random(seed) % 4 != 0);
    rd_o            = '0;
    if (rq.size() > 0 && (!bp_en_i || $random(seed) % 4 != 0)) begin
      rd_o.valid    = 1'b1;
      rd_o.data_end = 1'b1;
      rd_o.data     = rq.pop_front();
    end
  end

endmodule

// File: src/ddr_test_top.sv
`timescale 1ns/1ns

module ddr_test_top
  import ddr_app_pkg::*;
  import tester_pkg::*;
#(
  parameter int ROW_W = 14
) (
  input  logic         clk,
  input  logic         rstn,
  input  logic         calib_done_i,
  input  app_ready_t   app_rdy_i,
  input  app_rdata_t   app_rd_i,
  output app_cmd_t     app_cmd_o,
  output app_wdata_t   app_wr_o,
  output test_status_t status_o
);

  logic                  req;
  logic                  req_write;
  logic [APP_ADDR_W-1:0] req_addr;
  logic                  req_detect;
  logic                  port_done;
  logic                  pat_restart;
  logic                  pat_invert;
  logic [APP_DATA_W-1:0] pat_word;
  logic                  port_advance;
  logic                  chk_advance;
  logic                  rd_beat_done;
  logic                  mismatch;

  test_sequencer #(
    .ROW_W(ROW_W)
  ) i_test_sequencer (
    .clk           (clk),
    .rstn          (rstn),
    .calib_done_i  (calib_done_i),
    .port_done_i   (port_done),
    .rd_beat_done_i(rd_beat_done),
    .rd_data_i     (app_rd_i.data),
    .mismatch_i    (mismatch),
    .req_o         (req),
    .req_write_o   (req_write),
    .req_addr_o    (req_addr),
    .req_detect_o  (req_detect),
    .pat_restart_o (pat_restart),
    .pat_invert_o  (pat_invert),
    .status_o      (status_o)
  );

  ddr_app_port #(
    .ROW_W(ROW_W)
  ) i_ddr_app_port (
    .clk          (clk),
    .rstn         (rstn),
    .req_i        (req),
    .req_write_i  (req_write),
    .req_addr_i   (req_addr),
    .req_detect_i (req_detect),
    .wdata_i      (pat_word),
    .app_rdy_i    (app_rdy_i),
    .app_cmd_o    (app_cmd_o),
    .app_wr_o     (app_wr_o),
    .pat_advance_o(port_advance),
    .port_done_o  (port_done)
  );

  pattern_gen i_pattern_gen (
    .clk      (clk),
    .rstn     (rstn),
    .restart_i(pat_restart),
    .advance_i(port_advance | chk_advance),
    .invert_i (pat_invert),
    .word_o   (pat_word)
  );

  // detection reads are compared in the sequencer instead
  read_checker i_read_checker (
    .clk        (clk),
    .rstn       (rstn),
    .app_rd_i   (app_rd_i),
    .expected_i (pat_word),
    .check_en_i (~req_detect),
    .advance_o  (chk_advance),
    .beat_done_o(rd_beat_done),
    .mismatch_o (mismatch)
  );

endmodule

// File: src/test_sequencer.sv
`timescale 1ns/1ns

module test_sequencer
  import ddr_app_pkg::*;
  import tester_pkg::*;
#(
  parameter int ROW_W = 14
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  calib_done_i,
  input  logic                  port_done_i,
  input  logic                  rd_beat_done_i,
  input  logic [APP_DATA_W-1:0] rd_data_i,
  input  logic                  mismatch_i,
  output logic                  req_o,
  output logic                  req_write_o,
  output logic [APP_ADDR_W-1:0] req_addr_o,
  output logic                  req_detect_o,
  output logic                  pat_restart_o,
  output logic                  pat_invert_o,
  output test_status_t          status_o
);

  localparam int LIN_W = ROW_W + BANK_W + COL_W;
  localparam int CNT_W = $clog2(CALIB_HOLD);

  test_phase_t           phase;
  test_status_t          status_q;
  logic [CNT_W-1:0]      calib_cnt;
  logic [1:0]            det_step;
  logic                  busy;
  logic                  settle;
  logic [APP_ADDR_W-1:0] addr;
  logic [APP_ADDR_W-1:0] top_addr;
  logic [APP_ADDR_W-1:0] region_last;
  logic                  last_burst;
  logic                  checking;

  // top linear row bit splits the two size halves
  assign top_addr    = APP_ADDR_W'(1) << (LIN_W - 1);
  assign region_last = (APP_ADDR_W'(1) << (status_q.mem_large ? LIN_W : LIN_W - 1))
                     - APP_ADDR_W'(BURST_ADDR_STEP);
  assign last_burst  = (addr == region_last);
  assign checking    = (phase == check) || (phase == inv_check);

  assign req_detect_o = (phase == detect);
  assign pat_invert_o = (phase == inv_fill) || (phase == inv_check);
  assign status_o     = status_q;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      phase         <= wait_init;
      status_q      <= '0;
      calib_cnt     <= '0;
      det_step      <= '0;
      busy          <= 1'b0;
      settle        <= 1'b0;
      addr          <= '0;
      req_o         <= 1'b0;
      req_write_o   <= 1'b0;
      req_addr_o    <= '0;
      pat_restart_o <= 1'b0;
    end else begin
      req_o         <= 1'b0;
      pat_restart_o <= 1'b0;
      if (checking && mismatch_i) begin
        phase               <= failed;
        status_q.done       <= 1'b1;
        status_q.mismatch   <= 1'b1;
        status_q.fail_phase <= phase;
      end else begin
        case (phase)
          wait_init: begin
            if (!calib_done_i) begin
              calib_cnt <= '0;
            end else if (calib_cnt == CNT_W'(CALIB_HOLD - 1)) begin
              phase <= detect;
            end else begin
              calib_cnt <= calib_cnt + 1'b1;
            end
          end
          // write low word, write high word, read back address zero
          detect: begin
            if (!busy) begin
              req_o       <= 1'b1;
              req_write_o <= (det_step != 2'd2);
              req_addr_o  <= (det_step == 2'd1) ? top_addr : '0;
              busy        <= 1'b1;
            end else if (det_step != 2'd2) begin
              if (port_done_i) begin
                busy     <= 1'b0;
                det_step <= det_step + 1'b1;
              end
            end else if (rd_beat_done_i) begin
              busy <= 1'b0;
              if (rd_data_i == PAT_LOW || rd_data_i == PAT_HIGH) begin
                // high word at zero means the top bit aliased
                status_q.mem_large <= (rd_data_i == PAT_LOW);
                phase              <= fill;
                addr               <= '0;
                pat_restart_o      <= 1'b1;
              end else begin
                status_q.detect_err <= 1'b1;
                status_q.done       <= 1'b1;
                phase               <= finished;
              end
            end
          end
          fill, inv_fill: begin
            if (!busy) begin
              req_o       <= 1'b1;
              req_write_o <= 1'b1;
              req_addr_o  <= addr;
              busy        <= 1'b1;
            end else if (port_done_i) begin
              busy <= 1'b0;
              if (last_burst) begin
                phase         <= (phase == fill) ? check : inv_check;
                addr          <= '0;
                pat_restart_o <= 1'b1;
              end else begin
                addr <= addr + APP_ADDR_W'(BURST_ADDR_STEP);
              end
            end
          end
          check, inv_check: begin
            // one idle cycle after the last beat lets its mismatch land here
            if (settle) begin
              settle <= 1'b0;
              busy   <= 1'b0;
              if (!last_burst) begin
                addr <= addr + APP_ADDR_W'(BURST_ADDR_STEP);
              end else if (phase == check) begin
                phase         <= inv_fill;
                addr          <= '0;
                pat_restart_o <= 1'b1;
              end else begin
                phase         <= finished;
                status_q.done <= 1'b1;
              end
            end else if (!busy) begin
              req_o       <= 1'b1;
              req_write_o <= 1'b0;
              req_addr_o  <= addr;
              busy        <= 1'b1;
            end else if (rd_beat_done_i) begin
              settle <= 1'b1;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

// File: src/ddr_app_port.sv
`timescale 1ns/1ns

module ddr_app_port
  import ddr_app_pkg::*;
  import tester_pkg::*;
#(
  parameter int ROW_W = 14
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  req_i,
  input  logic                  req_write_i,
  input  logic [APP_ADDR_W-1:0] req_addr_i,
  input  logic                  req_detect_i,
  input  logic [APP_DATA_W-1:0] wdata_i,
  input  app_ready_t            app_rdy_i,
  output app_cmd_t              app_cmd_o,
  output app_wdata_t            app_wr_o,
  output logic                  pat_advance_o,
  output logic                  port_done_o
);

  localparam int LIN_W  = ROW_W + BANK_W + COL_W;
  localparam int BEAT_W = $clog2(BURST_BEATS);

  typedef enum logic [2:0] {st_idle, st_beat, st_wcmd, st_det, st_rcmd} port_state_t;

  port_state_t       state;
  logic [BEAT_W-1:0] beat_cnt;
  logic              is_write;
  logic              is_detect;
  logic [LIN_W-1:0]  addr_q;
  logic [ROW_W-1:0]  row;
  logic [BANK_W-1:0] bank;
  logic [COL_W-1:0]  col;
  logic              beat_fire;
  logic              det_fire;
  logic              cmd_fire;

  // linear is row bank col, controller wants bank row col
  assign col  = addr_q[COL_W-1:0];
  assign bank = addr_q[COL_W +: BANK_W];
  assign row  = addr_q[COL_W + BANK_W +: ROW_W];

  assign beat_fire = (state == st_beat) && app_rdy_i.wdata_rdy;
  assign det_fire  = (state == st_det) && app_rdy_i.wdata_rdy && app_rdy_i.cmd_rdy;
  assign cmd_fire  = det_fire || (((state == st_wcmd) || (state == st_rcmd)) && app_rdy_i.cmd_rdy);

  assign app_wr_o.en       = beat_fire || det_fire;
  assign app_wr_o.data_end = beat_fire || det_fire;
  assign app_wr_o.data     = !is_detect ? wdata_i : (addr_q[LIN_W-1] ? PAT_HIGH : PAT_LOW);

  assign app_cmd_o.en        = cmd_fire;
  assign app_cmd_o.cmd       = is_write ? CMD_WR : CMD_RD;
  assign app_cmd_o.addr      = APP_ADDR_W'({bank, row, col});
  assign app_cmd_o.burst_num = is_detect ? 6'd0 : 6'(BURST_BEATS - 1);

  assign pat_advance_o = beat_fire;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state       <= st_idle;
      beat_cnt    <= '0;
      port_done_o <= 1'b0;
    end else begin
      port_done_o <= cmd_fire;
      case (state)
        st_idle: begin
          if (req_i) begin
            state <= !req_write_i ? st_rcmd : (req_detect_i ? st_det : st_beat);
          end
        end
        // all data beats go out before the write command
        st_beat: begin
          if (beat_fire) begin
            if (beat_cnt == BEAT_W'(BURST_BEATS - 1)) begin
              beat_cnt <= '0;
              state    <= st_wcmd;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        st_wcmd, st_det, st_rcmd: begin
          if (cmd_fire) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_i && state == st_idle) begin
      is_write  <= req_write_i;
      is_detect <= req_detect_i;
      addr_q    <= req_addr_i[LIN_W-1:0];
    end
  end

endmodule

// File: src/read_checker.sv
`timescale 1ns/1ns

module read_checker
  import ddr_app_pkg::*;
  import tester_pkg::*;
(
  input  logic                  clk,
  input  logic                  rstn,
  input  app_rdata_t            app_rd_i,
  input  logic [APP_DATA_W-1:0] expected_i,
  input  logic                  check_en_i,
  output logic                  advance_o,
  output logic                  beat_done_o,
  output logic                  mismatch_o
);

  localparam int BEAT_W = $clog2(BURST_BEATS);

  logic [BEAT_W-1:0] beat_cnt;
  logic              compare;
  logic              last_beat;

  assign compare   = app_rd_i.valid && check_en_i;
  assign last_beat = (beat_cnt == BEAT_W'(BURST_BEATS - 1));
  assign advance_o = compare;

  // detection reads are a single unchecked beat
  assign beat_done_o = app_rd_i.valid && (!check_en_i || last_beat);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      beat_cnt   <= '0;
      mismatch_o <= 1'b0;
    end else begin
      mismatch_o <= compare && (app_rd_i.data != expected_i);
      if (compare) begin
        beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
      end
    end
  end

endmodule

// File: src/pattern_gen.sv
`timescale 1ns/1ns

module pattern_gen
  import ddr_app_pkg::*;
  import tester_pkg::*;
(
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  restart_i,
  input  logic                  advance_i,
  input  logic                  invert_i,
  output logic [APP_DATA_W-1:0] word_o
);

  logic [APP_DATA_W-1:0] lfsr;

  // restart lands on the first word of the stream, not the bare seed
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lfsr <= LFSR_SEED;
    end else if (restart_i) begin
      lfsr <= next_pattern(LFSR_SEED);
    end else if (advance_i) begin
      lfsr <= next_pattern(lfsr);
    end
  end

  // inverted passes reuse the same stream
  assign word_o = invert_i ? ~lfsr : lfsr;

endmodule

// File: src/tester_pkg.sv
package tester_pkg;
  import ddr_app_pkg::*;

  localparam int BURST_BEATS     = 8;
  localparam int BURST_ADDR_STEP = 64;
  localparam int CALIB_HOLD      = 256;
  localparam int LFSR_STEPS      = 128;

  // size detection words, low half and high half
  localparam logic [APP_DATA_W-1:0] PAT_LOW  = 128'h5A01_23FA_4567_89AB_CDEF_0123_4567_89AB;
  localparam logic [APP_DATA_W-1:0] PAT_HIGH = 128'h5329_0AB2_FA05_00FF_89AB_CDEF_0123_4567;
  localparam logic [APP_DATA_W-1:0] LFSR_SEED = 128'h0123_4567_890A_BCDE_FEDC_BA98_7654_3210;

  typedef enum logic [2:0] {
    wait_init, detect, fill, check, inv_fill, inv_check, failed, finished
  } test_phase_t;

  typedef struct packed {
    logic        done;
    logic        mem_large;
    logic        detect_err;
    logic        mismatch;
    test_phase_t fail_phase;
  } test_status_t;

  // one full word of lfsr steps, taps 68 67 66 63
  function automatic logic [APP_DATA_W-1:0] next_pattern(input logic [APP_DATA_W-1:0] cur);
    logic [APP_DATA_W-1:0] s;
    s = cur;
    for (int i = 0; i < LFSR_STEPS; i++) begin
      s = {s[APP_DATA_W-2:0], s[68] ^ s[67] ^ s[66] ^ s[63]};
    end
    return s;
  endfunction

endpackage

// File: src/ddr_app_pkg.sv
package ddr_app_pkg;

  // controller user interface widths
  localparam int APP_ADDR_W = 27;
  localparam int APP_DATA_W = 128;
  localparam int COL_W      = 10;
  localparam int BANK_W     = 3;

  localparam logic [2:0] CMD_WR = 3'd0;
  localparam logic [2:0] CMD_RD = 3'd1;

  typedef struct packed {
    logic                  en;
    logic [2:0]            cmd;
    logic [APP_ADDR_W-1:0] addr;
    logic [5:0]            burst_num;
  } app_cmd_t;

  typedef struct packed {
    logic                  en;
    logic                  data_end;
    logic [APP_DATA_W-1:0] data;
  } app_wdata_t;

  typedef struct packed {
    logic                  valid;
    logic                  data_end;
    logic [APP_DATA_W-1:0] data;
  } app_rdata_t;

  typedef struct packed {
    logic cmd_rdy;
    logic wdata_rdy;
  } app_ready_t;

endpackage
